// File: edge_capture_pkg.sv
`default_nettype none

package edge_capture_pkg;

    // Only bit 0 of a detector pixel carries the edge flag
    localparam int PIXEL_WIDTH = 8;

    // Frame geometry kept small for short simulations
    localparam int FRAME_W      = 32;
    localparam int FRAME_H      = 16;
    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

    localparam int PIXELS_PER_BYTE = 8;
    localparam int FRAME_BYTES     = FRAME_PIXELS / PIXELS_PER_BYTE;

    localparam int ADDR_WIDTH = $clog2(FRAME_BYTES);

    // One extra bit so a frame of all edges still fits
    localparam int COUNT_WIDTH = $clog2(FRAME_PIXELS) + 1;

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [7:0]             byte_t;
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// File: edge_pack_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module edge_pack_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     canny_de,
    input  edge_capture_pkg::pixel_t canny_data,
    output logic                     we,
    output edge_capture_pkg::byte_t  wdata,
    output edge_capture_pkg::addr_t  waddr,
    output logic                     frame_tick
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_ADDR,
        ST_DONE
    } state_t;

    state_t state, state_next;

    edge_capture_pkg::byte_t wdata_reg, wdata_next;
    edge_capture_pkg::addr_t waddr_reg, waddr_next;
    logic [2:0]              pixel_cnt_reg, pixel_cnt_next;
    logic                    we_reg, we_next;
    logic                    frame_tick_reg, frame_tick_next;
    logic                    last_addr;

    assign we         = we_reg;
    assign wdata      = wdata_reg;
    assign waddr      = waddr_reg;
    assign frame_tick = frame_tick_reg;

    assign last_addr = (waddr_reg == edge_capture_pkg::addr_t'(edge_capture_pkg::FRAME_BYTES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ST_IDLE;
            waddr_reg      <= '0;
            pixel_cnt_reg  <= '0;
            we_reg         <= 1'b0;
            frame_tick_reg <= 1'b0;
        end else begin
            state          <= state_next;
            waddr_reg      <= waddr_next;
            pixel_cnt_reg  <= pixel_cnt_next;
            we_reg         <= we_next;
            frame_tick_reg <= frame_tick_next;
        end
    end

    always_ff @(posedge clk) begin
        wdata_reg <= wdata_next;
    end

    always_comb begin
        state_next      = state;
        wdata_next      = wdata_reg;
        waddr_next      = waddr_reg;
        pixel_cnt_next  = pixel_cnt_reg;
        we_next         = 1'b0;
        frame_tick_next = 1'b0;

        case (state)
            ST_IDLE: begin
                if (canny_de) begin
                    wdata_next[pixel_cnt_reg] = canny_data[0];
                    pixel_cnt_next            = pixel_cnt_reg + 3'd1;
                    state_next                = ST_DATA;
                end
            end

            ST_DATA: begin
                if (canny_de) begin
                    wdata_next[pixel_cnt_reg] = canny_data[0];
                    if (pixel_cnt_reg == 3'd7) begin
                        // The eighth bit completes the byte and it is written in the next cycle
                        pixel_cnt_next = '0;
                        we_next        = 1'b1;
                        state_next     = last_addr ? ST_DONE : ST_ADDR;
                    end else begin
                        pixel_cnt_next = pixel_cnt_reg + 3'd1;
                    end
                end
            end

            ST_ADDR: begin
                // The write is on the bus now, so the next byte can start filling
                waddr_next = waddr_reg + edge_capture_pkg::addr_t'(1);
                if (canny_de) begin
                    wdata_next[pixel_cnt_reg] = canny_data[0];
                    pixel_cnt_next            = pixel_cnt_reg + 3'd1;
                    state_next                = ST_DATA;
                end else begin
                    state_next = ST_IDLE;
                end
            end

            ST_DONE: begin
                // Pixels offered here are dropped
                frame_tick_next = 1'b1;
                waddr_next      = '0;
                state_next      = ST_IDLE;
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                    clk,
    input  logic                    we,
    input  edge_capture_pkg::addr_t waddr,
    input  edge_capture_pkg::byte_t wdata,
    input  edge_capture_pkg::addr_t rd_addr,
    output edge_capture_pkg::byte_t rd_data
);

    edge_capture_pkg::byte_t mem [0:edge_capture_pkg::FRAME_BYTES-1];
    edge_capture_pkg::byte_t rd_data_reg;

    assign rd_data = rd_data_reg;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // The read is registered so a read of the address being written returns the old byte
    always_ff @(posedge clk) begin
        rd_data_reg <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: edge_counter.sv
`timescale 1ns/1ps
`default_nettype none

module edge_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  edge_capture_pkg::byte_t  wdata,
    input  logic                     frame_tick,
    output edge_capture_pkg::count_t edge_count,
    output logic                     count_valid
);

    edge_capture_pkg::count_t sum_reg;
    edge_capture_pkg::count_t edge_count_reg;
    edge_capture_pkg::count_t byte_ones;
    logic                     count_valid_reg;

    assign edge_count  = edge_count_reg;
    assign count_valid = count_valid_reg;

    // Number of edge pixels in the byte being written
    always_comb begin
        byte_ones = '0;
        for (int i = 0; i < 8; i++) begin
            byte_ones = byte_ones + edge_capture_pkg::count_t'(wdata[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_reg         <= '0;
            edge_count_reg  <= '0;
            count_valid_reg <= 1'b0;
        end else begin
            count_valid_reg <= frame_tick;
            if (frame_tick) begin
                edge_count_reg <= sum_reg;
                sum_reg        <= '0;
            end else if (we) begin
                sum_reg <= sum_reg + byte_ones;
            end
        end
    end

endmodule

`default_nettype wire

// File: edge_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module edge_capture_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     canny_de,
    input  edge_capture_pkg::pixel_t canny_data,
    input  edge_capture_pkg::addr_t  rd_addr,
    output edge_capture_pkg::byte_t  rd_data,
    output logic                     we,
    output edge_capture_pkg::addr_t  waddr,
    output edge_capture_pkg::byte_t  wdata,
    output logic                     frame_tick,
    output edge_capture_pkg::count_t edge_count,
    output logic                     count_valid
);

    // Packs the edge stream into bytes and drives the write port
    edge_pack_fsm u_edge_pack_fsm (
        .clk        (clk),
        .reset      (reset),
        .canny_de   (canny_de),
        .canny_data (canny_data),
        .we         (we),
        .wdata      (wdata),
        .waddr      (waddr),
        .frame_tick (frame_tick)
    );

    frame_buffer u_frame_buffer (
        .clk     (clk),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Watches the same write port and totals the edges per frame
    edge_counter u_edge_counter (
        .clk         (clk),
        .reset       (reset),
        .we          (we),
        .wdata       (wdata),
        .frame_tick  (frame_tick),
        .edge_count  (edge_count),
        .count_valid (count_valid)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // The clock toggles every 10 ns so the first rising edge comes at 10 ns
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: tb_edge_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_edge_capture;

    localparam int WAIT_LIMIT = 50;

    // Position of one pixel within a frame
    typedef logic [edge_capture_pkg::ADDR_WIDTH+2:0] pixel_idx_t;

    logic                     clk;
    logic                     reset;
    logic                     canny_de;
    edge_capture_pkg::pixel_t canny_data;
    edge_capture_pkg::addr_t  rd_addr;
    edge_capture_pkg::byte_t  rd_data;
    logic                     we;
    edge_capture_pkg::addr_t  waddr;
    edge_capture_pkg::byte_t  wdata;
    logic                     frame_tick;
    edge_capture_pkg::count_t edge_count;
    logic                     count_valid;

    integer                                    seed;
    logic [edge_capture_pkg::FRAME_PIXELS-1:0] frame_bits;

    int   wr_count;
    int   pix_phase;
    int   held_count;
    logic expect_we;
    logic expect_tick;
    logic expect_valid;
    logic last_write_now;

    tb_clock_gen u_tb_clock_gen (
        .clk (clk)
    );

    edge_capture_top u_edge_capture_top (
        .clk         (clk),
        .reset       (reset),
        .canny_de    (canny_de),
        .canny_data  (canny_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .frame_tick  (frame_tick),
        .edge_count  (edge_count),
        .count_valid (count_valid)
    );

    // Builds a byte from eight consecutive edge bits with the first pixel in bit 0
    function automatic edge_capture_pkg::byte_t expected_byte(
        input logic [edge_capture_pkg::FRAME_PIXELS-1:0] bits,
        input edge_capture_pkg::addr_t                  addr
    );
        edge_capture_pkg::byte_t b;
        pixel_idx_t              idx;
        b   = '0;
        idx = {addr, 3'd0};
        repeat (8) begin
            b   = {bits[idx], b[7:1]};
            idx = idx + pixel_idx_t'(1);
        end
        return b;
    endfunction

    function automatic int expected_total(
        input logic [edge_capture_pkg::FRAME_PIXELS-1:0] bits
    );
        pixel_idx_t idx;
        int         total;
        idx   = '0;
        total = 0;
        repeat (edge_capture_pkg::FRAME_PIXELS) begin
            if (bits[idx]) begin
                total++;
            end
            idx = idx + pixel_idx_t'(1);
        end
        return total;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic make_random_frame();
        pixel_idx_t  idx;
        logic [31:0] r;
        idx = '0;
        repeat (edge_capture_pkg::FRAME_PIXELS) begin
            r               = $random(seed);
            frame_bits[idx] = r[0];
            idx             = idx + pixel_idx_t'(1);
        end
    endtask

    task automatic send_frame(input logic with_gaps);
        pixel_idx_t  idx;
        logic [31:0] r;
        idx = '0;
        repeat (edge_capture_pkg::FRAME_PIXELS) begin
            r = $random(seed);
            while (with_gaps && r[1:0] == 2'b00) begin
                @(posedge clk);
                #2;
                canny_de   = 1'b0;
                canny_data = edge_capture_pkg::pixel_t'(r);
                r          = $random(seed);
            end
            @(posedge clk);
            #2;
            canny_de = 1'b1;
            // Upper bits are noise that the packer has to ignore
            canny_data = {r[7:1], frame_bits[idx]};
            idx        = idx + pixel_idx_t'(1);
        end
        @(posedge clk);
        #2;
        canny_de   = 1'b0;
        canny_data = '0;
    endtask

    task automatic wait_for_frame_tick();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("Timed out: frame_tick never came after the frame was sent");
            end
        end while (!frame_tick);
    endtask

    task automatic wait_for_count_valid();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("Timed out: count_valid never came after frame_tick");
            end
        end while (!count_valid);
    endtask

    task automatic finish_frame();
        wait_for_frame_tick();
        wait_for_count_valid();
        @(posedge clk);
        #2;
    endtask

    task automatic read_back();
        int a;
        for (a = 0; a < edge_capture_pkg::FRAME_BYTES; a++) begin
            @(posedge clk);
            #2;
            rd_addr = edge_capture_pkg::addr_t'(a);
            @(posedge clk);
            @(negedge clk);
            assert (rd_data == expected_byte(frame_bits, edge_capture_pkg::addr_t'(a)))
                else abort_run($sformatf("error: %0d ns: rd_data at %0d is %h, expected %h",
                    $time, a, rd_data, expected_byte(frame_bits, edge_capture_pkg::addr_t'(a))));
        end
        @(posedge clk);
        #2;
    endtask

    // Compares every cycle at the falling edge, where outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            wr_count     = 0;
            pix_phase    = 0;
            held_count   = 0;
            expect_we    = 1'b0;
            expect_tick  = 1'b0;
            expect_valid = 1'b0;
        end else begin
            assert (we == expect_we)
                else abort_run($sformatf("error: %0d ns: we is %0b, expected %0b",
                    $time, we, expect_we));
            if (we) begin
                assert (wr_count < edge_capture_pkg::FRAME_BYTES)
                    else abort_run($sformatf("error: %0d ns: more than %0d writes in one frame",
                        $time, edge_capture_pkg::FRAME_BYTES));
                assert (int'(waddr) == wr_count)
                    else abort_run($sformatf("error: %0d ns: waddr is %0d, expected %0d",
                        $time, waddr, wr_count));
                assert (wdata == expected_byte(frame_bits, edge_capture_pkg::addr_t'(wr_count)))
                    else abort_run($sformatf("error: %0d ns: wdata at %0d is %h, expected %h",
                        $time, wr_count, wdata,
                        expected_byte(frame_bits, edge_capture_pkg::addr_t'(wr_count))));
            end
            assert (frame_tick == expect_tick)
                else abort_run($sformatf("error: %0d ns: frame_tick is %0b, expected %0b",
                    $time, frame_tick, expect_tick));
            assert (count_valid == expect_valid)
                else abort_run($sformatf("error: %0d ns: count_valid is %0b, expected %0b",
                    $time, count_valid, expect_valid));
            if (count_valid) begin
                assert (int'(edge_count) == expected_total(frame_bits))
                    else abort_run($sformatf("error: %0d ns: edge_count is %0d, expected %0d",
                        $time, edge_count, expected_total(frame_bits)));
                held_count = expected_total(frame_bits);
            end else begin
                assert (int'(edge_count) == held_count)
                    else abort_run($sformatf("error: %0d ns: edge_count moved to %0d, held %0d",
                        $time, edge_count, held_count));
            end
            if (frame_tick) begin
                assert (wr_count == edge_capture_pkg::FRAME_BYTES)
                    else abort_run($sformatf("error: %0d ns: frame ended after %0d writes",
                        $time, wr_count));
                wr_count = 0;
            end

            last_write_now = expect_we && (wr_count == edge_capture_pkg::FRAME_BYTES - 1);
            expect_valid   = expect_tick;
            expect_tick    = last_write_now;
            expect_we      = 1'b0;
            // A pixel offered while the last byte of a frame is on the bus gets dropped
            if (canny_de && !last_write_now) begin
                if (pix_phase == 7) begin
                    expect_we = 1'b1;
                end
                pix_phase = (pix_phase + 1) % 8;
            end
            if (we) begin
                wr_count++;
            end
        end
    end

    initial begin
        int i;
        seed       = 32'he112;
        reset      = 1'b1;
        canny_de   = 1'b0;
        canny_data = '0;
        rd_addr    = '0;
        frame_bits = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            assert (!we && !frame_tick && !count_valid && waddr == '0 && edge_count == '0)
                else abort_run($sformatf("error: %0d ns: outputs not idle after reset", $time));
        end

        // Random edges with gaps in canny_de
        make_random_frame();
        send_frame(1'b1);
        finish_frame();
        read_back();

        // One pixel per cycle with no gaps
        make_random_frame();
        send_frame(1'b0);
        finish_frame();

        frame_bits = '0;
        send_frame(1'b0);
        finish_frame();

        frame_bits = '1;
        send_frame(1'b1);
        finish_frame();
        read_back();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
edge_capture_pkg.sv
edge_pack_fsm.sv
frame_buffer.sv
edge_counter.sv
edge_capture_top.sv
tb_clock_gen.sv
tb_edge_capture.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_edge_capture -f verilog.f &&
./obj_dir/Vtb_edge_capture | tee /dev/stderr | grep -q ">>> PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
